// ==== logic/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

  localparam int num_lanes    = 2;
  localparam int num_rd_ports = 2 * num_lanes;  // rn and rm for each lane
  localparam int num_regs     = 31;             // x31 is not stored
  localparam int data_w       = 64;
  localparam int inst_w       = 32;
  localparam int reg_addr_w   = 5;
  localparam int opc_w        = 11;             // Instruction bits 31..21

  typedef logic [data_w-1:0]     data_t;
  typedef logic [inst_w-1:0]     inst_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [opc_w-1:0]      opcode_t;

  // XZR, reads as zero and swallows writes
  localparam reg_addr_t zero_reg = reg_addr_t'(31);

  // R-format opcodes of the supported subset
  localparam opcode_t op_add = 11'b100_0101_1000;
  localparam opcode_t op_sub = 11'b110_0101_1000;
  localparam opcode_t op_and = 11'b100_0101_0000;
  localparam opcode_t op_orr = 11'b101_0101_0000;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_orr
  } alu_op_t;

endpackage

`default_nettype wire

// ==== logic/lane_if.sv ====
`default_nettype none

// Issue unit to one execution lane, plus the lane's bypass back to issue
interface lane_issue_if import lane_pkg::*; ();

  logic      valid;     // Single-cycle strobe
  alu_op_t   op;
  data_t     opnd_a;    // rn value after forwarding
  data_t     opnd_b;    // rm value after forwarding
  reg_addr_t rd;
  logic      wen;

  logic      fwd_wen;   // Operand stage holds a writing instruction
  reg_addr_t fwd_rd;
  data_t     fwd_data;  // Combinational ALU result

  modport issue (
    output valid, op, opnd_a, opnd_b, rd, wen,
    input  fwd_wen, fwd_rd, fwd_data
  );

  modport lane (
    input  valid, op, opnd_a, opnd_b, rd, wen,
    output fwd_wen, fwd_rd, fwd_data
  );

endinterface

// Lane result stage toward writeback, also tapped for forwarding
interface lane_result_if import lane_pkg::*; ();

  logic      valid;
  logic      wen;       // Already qualified by valid in the lane
  reg_addr_t rd;
  data_t     data;

  modport lane      (output valid, wen, rd, data);
  modport writeback (input  valid, wen, rd, data);
  modport issue     (input  valid, wen, rd, data);

endinterface

`default_nettype wire

// ==== logic/issue_unit.sv ====
`default_nettype none

module issue_unit import lane_pkg::*; (
  input  logic         issue_valid,
  input  inst_t        issue_inst [num_lanes],
  input  data_t        rd_data    [num_rd_ports],
  output reg_addr_t    rd_addr    [num_rd_ports],
  lane_issue_if.issue  iss        [num_lanes],
  lane_result_if.issue res        [num_lanes]
);

  // Forwarding sources, flattened so they can be indexed in a loop
  logic      byp_wen  [num_lanes];
  reg_addr_t byp_rd   [num_lanes];
  data_t     byp_data [num_lanes];
  logic      res_wen  [num_lanes];
  reg_addr_t res_rd   [num_lanes];
  data_t     res_data [num_lanes];

  data_t     opnd     [num_rd_ports];  // Port 2l is rn, 2l+1 is rm of lane l

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    opcode_t opcode;
    alu_op_t op;
    logic    legal;

    assign opcode = issue_inst[l][31:21];

    // Source register fields
    assign rd_addr[2*l]   = issue_inst[l][9:5];
    assign rd_addr[2*l+1] = issue_inst[l][20:16];

    always_comb begin
      legal = 1'b1;
      op    = alu_add;
      case (opcode)
        op_add:  op = alu_add;
        op_sub:  op = alu_sub;
        op_and:  op = alu_and;
        op_orr:  op = alu_orr;
        default: legal = 1'b0;  // Retires without a write
      endcase
    end

    assign iss[l].valid  = issue_valid;
    assign iss[l].op     = op;
    assign iss[l].opnd_a = opnd[2*l];
    assign iss[l].opnd_b = opnd[2*l+1];
    assign iss[l].rd     = issue_inst[l][4:0];
    assign iss[l].wen    = legal && (issue_inst[l][4:0] != zero_reg);

    // Pair issued one cycle ago, still in the operand register
    assign byp_wen[l]  = iss[l].fwd_wen;
    assign byp_rd[l]   = iss[l].fwd_rd;
    assign byp_data[l] = iss[l].fwd_data;

    // Pair issued two cycles ago, in the result register
    assign res_wen[l]  = res[l].valid && res[l].wen;
    assign res_rd[l]   = res[l].rd;
    assign res_data[l] = res[l].data;
  end

  // Later matches override earlier ones, so the loops run from lowest
  // priority up: register file, results lane 0/1, bypass lane 0/1
  always_comb begin
    for (int p = 0; p < num_rd_ports; p++) begin
      opnd[p] = rd_data[p];
      for (int l = 0; l < num_lanes; l++) begin
        if (res_wen[l] && (res_rd[l] == rd_addr[p])) begin
          opnd[p] = res_data[l];
        end
      end
      for (int l = 0; l < num_lanes; l++) begin
        if (byp_wen[l] && (byp_rd[l] == rd_addr[p])) begin
          opnd[p] = byp_data[l];
        end
      end
      if (rd_addr[p] == zero_reg) begin
        opnd[p] = '0;  // XZR
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/exec_lane.sv ====
`default_nettype none

module exec_lane import lane_pkg::*; (
  input  logic       CLOCK,
  input  logic       arst_n,
  lane_issue_if.lane iss,
  lane_result_if.lane res
);

  // Operand register
  logic      valid_q;
  logic      wen_q;
  alu_op_t   op_q;
  data_t     a_q;
  data_t     b_q;
  reg_addr_t rd_q;

  data_t     alu_out;

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
    end else begin
      valid_q <= iss.valid;
      wen_q   <= iss.valid && iss.wen;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (iss.valid) begin
      op_q <= iss.op;
      a_q  <= iss.opnd_a;
      b_q  <= iss.opnd_b;
      rd_q <= iss.rd;
    end
  end

  always_comb begin
    case (op_q)
      alu_add: alu_out = a_q + b_q;
      alu_sub: alu_out = a_q - b_q;  // rn - rm
      alu_and: alu_out = a_q & b_q;
      default: alu_out = a_q | b_q;  // alu_orr
    endcase
  end

  // Bypass to the issue unit for the next pair
  assign iss.fwd_wen  = valid_q && wen_q;
  assign iss.fwd_rd   = rd_q;
  assign iss.fwd_data = alu_out;

  // Result register
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      res.valid <= 1'b0;
      res.wen   <= 1'b0;
    end else begin
      res.valid <= valid_q;
      res.wen   <= valid_q && wen_q;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (valid_q) begin
      res.rd   <= rd_q;
      res.data <= alu_out;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file import lane_pkg::*; (
  input  logic             CLOCK,
  input  logic             arst_n,
  input  reg_addr_t        rd_addr      [num_rd_ports],
  lane_result_if.writeback wb           [num_lanes],
  output data_t            rd_data      [num_rd_ports],
  output logic             retire_valid [num_lanes],
  output logic             retire_write [num_lanes],
  output reg_addr_t        retire_rd    [num_lanes],
  output data_t            retire_data  [num_lanes]
);

  data_t     regs     [num_regs];  // x0..x30

  logic      wb_valid [num_lanes];
  logic      wb_wen   [num_lanes];
  reg_addr_t wb_rd    [num_lanes];
  data_t     wb_data  [num_lanes];

  for (genvar l = 0; l < num_lanes; l++) begin : g_wb
    assign wb_valid[l] = wb[l].valid;
    assign wb_wen[l]   = wb[l].wen;
    assign wb_rd[l]    = wb[l].rd;
    assign wb_data[l]  = wb[l].data;
  end

  // Lane order matters here, the higher lane lands last and wins
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= data_t'(i);  // xi starts out holding i
      end
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        if (wb_wen[l]) begin
          regs[wb_rd[l]] <= wb_data[l];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < num_rd_ports; p++) begin
      rd_data[p] = (rd_addr[p] == zero_reg) ? '0 : regs[rd_addr[p]];
    end
  end

  // Retire stage, captured on the same edge as the write
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int l = 0; l < num_lanes; l++) begin
        retire_valid[l] <= 1'b0;
        retire_write[l] <= 1'b0;
      end
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        retire_valid[l] <= wb_valid[l];
        retire_write[l] <= wb_wen[l];
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    for (int l = 0; l < num_lanes; l++) begin
      if (wb_valid[l]) begin
        retire_rd[l]   <= wb_rd[l];
        retire_data[l] <= wb_data[l];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dual_issue_top.sv ====
`default_nettype none

module dual_issue_top import lane_pkg::*; (
  input  logic      CLOCK,
  input  logic      arst_n,
  input  logic      issue_valid,
  input  inst_t     issue_inst   [num_lanes],
  output logic      retire_valid [num_lanes],
  output logic      retire_write [num_lanes],
  output reg_addr_t retire_rd    [num_lanes],
  output data_t     retire_data  [num_lanes]
);

  reg_addr_t rd_addr [num_rd_ports];
  data_t     rd_data [num_rd_ports];

  lane_issue_if  iss_if [num_lanes] ();
  lane_result_if res_if [num_lanes] ();

  // Decode, operand read and forwarding for the whole pair
  issue_unit u_issue (
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .iss         (iss_if),
    .res         (res_if)
  );

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    exec_lane u_lane (
      .CLOCK  (CLOCK),
      .arst_n (arst_n),
      .iss    (iss_if[l]),
      .res    (res_if[l])
    );
  end

  // Drains both lanes and drives the retire ports
  reg_file u_rf (
    .CLOCK        (CLOCK),
    .arst_n       (arst_n),
    .rd_addr      (rd_addr),
    .wb           (res_if),
    .rd_data      (rd_data),
    .retire_valid (retire_valid),
    .retire_write (retire_write),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// ==== verification/pipeline_checker.sv ====
`default_nettype none

module pipeline_checker import lane_pkg::*; (
  input wire logic CLOCK,
  input wire logic arst_n,
  input wire logic issue_valid,
  input wire logic retire_valid [num_lanes],
  input wire logic retire_write [num_lanes],
  input wire data_t retire_data [num_lanes]
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // Assertion failures so far

  for (genvar l = 0; l < num_lanes; l++) begin : g_chk
    // Retire is registered after edge k+2, so it is sampled on edge k+3
    a_latency : assert property (@(posedge CLOCK) disable iff (!arst_n)
      issue_valid |-> ##3 retire_valid[l])
      else begin
        $error("lane %0d did not retire two edges after issue", l);
        fail_count++;
      end

    a_no_spurious : assert property (@(posedge CLOCK) disable iff (!arst_n)
      retire_valid[l] |-> $past(issue_valid, 3))
      else begin
        $error("lane %0d retired with no matching issue", l);
        fail_count++;
      end

    a_write_valid : assert property (@(posedge CLOCK) disable iff (!arst_n)
      retire_write[l] |-> retire_valid[l])
      else begin
        $error("lane %0d write without valid", l);
        fail_count++;
      end

    a_data_known : assert property (@(posedge CLOCK) disable iff (!arst_n)
      retire_valid[l] |-> !$isunknown(retire_data[l]))
      else begin
        $error("lane %0d retire data has unknown bits", l);
        fail_count++;
      end

    a_reset_quiet : assert property (@(posedge CLOCK)
      !arst_n |-> !retire_valid[l])
      else begin
        $error("lane %0d retire valid during reset", l);
        fail_count++;
      end
  end

endmodule

`default_nettype wire

// ==== verification/retire_monitor.sv ====
`default_nettype none

module retire_monitor import lane_pkg::*; (
  input  wire logic      CLOCK,
  input  wire logic      arst_n,
  input  wire logic      issue_valid,
  input  wire inst_t     issue_inst   [num_lanes],
  input  wire logic      retire_valid [num_lanes],
  input  wire logic      retire_write [num_lanes],
  input  wire reg_addr_t retire_rd    [num_lanes],
  input  wire data_t     retire_data  [num_lanes],
  output int             errors,
  output int             checks,
  output int             pending
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic      wr;
    reg_addr_t rd;
    data_t     data;
  } exp_t;

  data_t shadow [32];  // x31 stays zero
  exp_t  exp_q  [$];   // Two entries per pair with lane 0 first

  initial begin
    errors  = 0;
    checks  = 0;
    pending = 0;
  end

  // Does the instruction write a register at all
  function automatic logic ref_writes(input inst_t inst);
    logic [10:0] opc;
    opc = inst[31:21];
    if (inst[4:0] == 5'd31) return 1'b0;
    return (opc == op_add) || (opc == op_sub) || (opc == op_and) || (opc == op_orr);
  endfunction

  // Result of one instruction given its operand values
  function automatic data_t ref_result(input inst_t inst, input data_t a, input data_t b);
    logic [10:0] opc;
    opc = inst[31:21];
    if (opc == op_add) return a + b;
    if (opc == op_sub) return a - b;
    if (opc == op_and) return a & b;
    return a | b;
  endfunction

  always @(posedge CLOCK) begin
    exp_t e [num_lanes];
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) shadow[i] = (i == 31) ? '0 : data_t'(i);
      exp_q.delete();
    end else if (issue_valid) begin
      // Both lanes read the state from before the pair
      for (int l = 0; l < num_lanes; l++) begin
        e[l].wr   = ref_writes(issue_inst[l]);
        e[l].rd   = issue_inst[l][4:0];
        e[l].data = ref_result(issue_inst[l], shadow[issue_inst[l][9:5]],
                               shadow[issue_inst[l][20:16]]);
      end
      for (int l = 0; l < num_lanes; l++) begin
        if (e[l].wr) shadow[e[l].rd] = e[l].data;  // Lane 1 lands last
        exp_q.push_back(e[l]);
      end
    end
    pending = exp_q.size() / num_lanes;
  end

  // Retire outputs change on the rising edge, so look at them mid-cycle
  always @(negedge CLOCK) begin
    exp_t e;
    if (arst_n && (retire_valid[0] || retire_valid[1])) begin
      if (retire_valid[0] !== retire_valid[1]) begin
        $display("lanes retired out of step, valid lane0=%b lane1=%b",
                 retire_valid[0], retire_valid[1]);
        errors++;
      end
      if (exp_q.size() < num_lanes) begin
        $display("a pair retired with no issued pair outstanding");
        errors++;
      end else begin
        for (int l = 0; l < num_lanes; l++) begin
          e = exp_q.pop_front();
          checks++;
          if (retire_write[l] !== e.wr) begin
            $display("ERROR retire_write[%0d] got %h expected %h", l, retire_write[l], e.wr);
            errors++;
          end
          if (retire_rd[l] !== e.rd) begin
            $display("ERROR retire_rd[%0d] got %h expected %h", l, retire_rd[l], e.rd);
            errors++;
          end
          if (e.wr && retire_data[l] !== e.data) begin
            $display("ERROR retire_data[%0d] got %h expected %h", l, retire_data[l], e.data);
            errors++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
`default_nettype none

module tb_top import lane_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic      CLOCK;
  logic      arst_n;
  logic      issue_valid;
  inst_t     issue_inst   [num_lanes];
  logic      retire_valid [num_lanes];
  logic      retire_write [num_lanes];
  reg_addr_t retire_rd    [num_lanes];
  data_t     retire_data  [num_lanes];

  int          mon_errors;
  int          mon_checks;
  int          mon_pending;
  int          other_errors;
  int          tests;
  logic [31:0] lcg_state;

  dual_issue_top dut_i (.*);

  retire_monitor mon_i (
    .CLOCK(CLOCK), .arst_n(arst_n), .issue_valid(issue_valid), .issue_inst(issue_inst),
    .retire_valid(retire_valid), .retire_write(retire_write), .retire_rd(retire_rd),
    .retire_data(retire_data), .errors(mon_errors), .checks(mon_checks),
    .pending(mon_pending)
  );

  bind dual_issue_top pipeline_checker chk_i (
    .CLOCK(CLOCK), .arst_n(arst_n), .issue_valid(issue_valid),
    .retire_valid(retire_valid), .retire_write(retire_write), .retire_data(retire_data)
  );

  always #4 CLOCK = ~CLOCK;  // 8 ns period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Monitor mismatches, drain timeouts and assertion failures together
  function automatic int error_total();
    return mon_errors + other_errors + dut_i.chk_i.fail_count;
  endfunction

  function automatic inst_t make_inst(input logic [10:0] opc, input reg_addr_t rd,
                                      input reg_addr_t rn, input reg_addr_t rm);
    return {opc, rm, 6'd0, rn, rd};
  endfunction

  // Random instruction with registers limited by mask and an optional illegal opcode
  function automatic inst_t rand_inst(input logic [4:0] mask, input logic allow_bad);
    logic [31:0] r;
    logic [10:0] opc;
    r = next_rand();
    case (r[31:30])
      2'd0:    opc = op_add;
      2'd1:    opc = op_sub;
      2'd2:    opc = op_and;
      default: opc = op_orr;
    endcase
    if (allow_bad && r[7:4] == 4'd0) opc = 11'h7ff;
    return make_inst(opc, r[12:8] & mask, r[20:16] & mask, r[28:24] & mask);
  endfunction

  task automatic issue_pair(input inst_t i0, input inst_t i1);
    @(negedge CLOCK);
    issue_valid   = 1'b1;
    issue_inst[0] = i0;
    issue_inst[1] = i1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge CLOCK);
      issue_valid = 1'b0;
    end
  endtask

  // Let the pipe drain, then print the test's line
  task automatic finish_test(input string name, input int err_start);
    int cyc;
    idle(1);
    for (cyc = 0; cyc < 50 && mon_pending != 0; cyc++) @(negedge CLOCK);
    if (mon_pending != 0) begin
      $display("timeout, %0d issued pairs never retired", mon_pending);
      other_errors++;
    end
    tests++;
    $display("test %0d %s: %0d errors", tests, name, error_total() - err_start);
  endtask

  initial begin
    int e0;
    CLOCK        = 1'b0;
    arst_n       = 1'b0;
    issue_valid  = 1'b0;
    issue_inst[0] = '0;
    issue_inst[1] = '0;
    other_errors = 0;
    tests        = 0;
    lcg_state    = 32'h73a58a9c;
    repeat (10) @(negedge CLOCK);
    arst_n = 1'b1;
    idle(2);

    e0 = error_total();
    for (int i = 0; i < 16; i++) begin
      issue_pair(make_inst(op_orr, reg_addr_t'(i), reg_addr_t'(i), 5'd31),
                 make_inst(op_orr, reg_addr_t'(i + 16), reg_addr_t'(i + 16), 5'd31));
    end
    finish_test("reset_values", e0);

    e0 = error_total();
    for (int i = 0; i < 40; i++) begin
      issue_pair(rand_inst(5'h1f, 1'b0), rand_inst(5'h1f, 1'b0));
      idle(3);
    end
    finish_test("independent_pairs", e0);

    e0 = error_total();
    for (int i = 0; i < 60; i++) begin
      issue_pair(rand_inst(5'h03, 1'b0), rand_inst(5'h03, 1'b0));
      if (i % 3 == 2) idle(1);  // Mix one- and two-cycle distances
    end
    finish_test("dependent_pairs", e0);

    e0 = error_total();
    issue_pair(make_inst(op_add, 5'd5, 5'd6, 5'd7), make_inst(op_sub, 5'd8, 5'd5, 5'd6));
    issue_pair(make_inst(op_add, 5'd9, 5'd1, 5'd2), make_inst(op_orr, 5'd9, 5'd3, 5'd4));
    issue_pair(make_inst(op_orr, 5'd10, 5'd9, 5'd31), make_inst(op_and, 5'd11, 5'd9, 5'd9));
    idle(4);
    issue_pair(make_inst(op_orr, 5'd12, 5'd9, 5'd31), make_inst(op_sub, 5'd13, 5'd8, 5'd5));
    finish_test("intra_pair", e0);

    e0 = error_total();
    issue_pair(make_inst(op_add, 5'd31, 5'd1, 5'd2), make_inst(11'h7ff, 5'd3, 5'd1, 5'd2));
    issue_pair(make_inst(op_orr, 5'd14, 5'd3, 5'd31), make_inst(op_orr, 5'd15, 5'd31, 5'd31));
    idle(4);
    issue_pair(make_inst(op_orr, 5'd16, 5'd3, 5'd31), make_inst(11'h000, 5'd4, 5'd3, 5'd3));
    finish_test("no_write", e0);

    e0 = error_total();
    for (int i = 0; i < 120; i++) begin
      logic [31:0] g;
      issue_pair(rand_inst(5'h1f, 1'b1), rand_inst(5'h1f, 1'b1));
      g = next_rand();
      idle(int'(g[31:30]));
    end
    finish_test("random_stream", e0);

    $display("tests %0d, lane checks %0d, errors %0d", tests, mon_checks, error_total());
    if (error_total() == 0 && mon_checks > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/lane_pkg.sv
logic/lane_if.sv
logic/issue_unit.sv
logic/exec_lane.sv
logic/reg_file.sv
logic/dual_issue_top.sv
verification/pipeline_checker.sv
verification/retire_monitor.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
